// ==== Makefile ====
SIM  := obj_dir/Vtb_frontend_top
SRCS := $(shell cat frontend_top.f)

.PHONY: run clean

$(SIM): frontend_top.f $(SRCS)
	verilator --binary --timing --top-module tb_frontend_top -f frontend_top.f \
		-o Vtb_frontend_top

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== frontend_top.f ====
hw/drac_pkg.sv
hw/decode_unit.sv
hw/instruction_queue.sv
hw/rename_table.sv
hw/frontend_top.sv
tests/tb_frontend_top.sv

// ==== hw/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,
    input  logic                   fetch_valid_i,
    input  logic                   page_fault_i,
    input  logic [31:0]            pc_i,
    input  logic [31:0]            instr_word_i,
    input  logic                   iq_full_i,
    output drac_pkg::id_ir_stage_t decode_o,
    output logic                   fetch_stall_o
);

    logic [6:0]  opcode;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        hold;
    drac_pkg::instr_t       decoded;
    drac_pkg::id_ir_stage_t next_bundle;

    assign opcode = instr_word_i[6:0];
    assign funct7 = instr_word_i[31:25];

    // Immediate formats, all sign extended from bit 31
    assign imm_i = {{20{instr_word_i[31]}}, instr_word_i[31:20]};
    assign imm_s = {{20{instr_word_i[31]}}, instr_word_i[31:25], instr_word_i[11:7]};
    assign imm_b = {{19{instr_word_i[31]}}, instr_word_i[31], instr_word_i[7],
                    instr_word_i[30:25], instr_word_i[11:8], 1'b0};
    assign imm_u = {instr_word_i[31:12], 12'b0};
    assign imm_j = {{11{instr_word_i[31]}}, instr_word_i[31], instr_word_i[19:12],
                    instr_word_i[20], instr_word_i[30:21], 1'b0};

    always_comb begin
        decoded          = '0;
        decoded.valid    = fetch_valid_i;
        decoded.pc       = pc_i;
        decoded.rs1      = instr_word_i[19:15];  // Raw fields, use flags tell which count
        decoded.rs2      = instr_word_i[24:20];
        decoded.rd       = instr_word_i[11:7];
        decoded.fu       = drac_pkg::NONE;
        case (opcode)
            drac_pkg::OP_LUI, drac_pkg::OP_AUIPC: begin
                decoded.imm      = imm_u;
                decoded.fu       = drac_pkg::ALU;
                decoded.regwrite = 1'b1;
            end
            drac_pkg::OP_JAL: begin
                decoded.imm      = imm_j;
                decoded.fu       = drac_pkg::JUMP;
                decoded.regwrite = 1'b1;  // Link register
            end
            drac_pkg::OP_JALR: begin
                decoded.imm      = imm_i;
                decoded.fu       = drac_pkg::JUMP;
                decoded.use_rs1  = 1'b1;
                decoded.regwrite = 1'b1;
            end
            drac_pkg::OP_BRANCH: begin
                decoded.imm      = imm_b;
                decoded.fu       = drac_pkg::BRANCH;
                decoded.use_rs1  = 1'b1;
                decoded.use_rs2  = 1'b1;
            end
            drac_pkg::OP_LOAD: begin
                decoded.imm      = imm_i;
                decoded.fu       = drac_pkg::LOAD;
                decoded.use_rs1  = 1'b1;
                decoded.regwrite = 1'b1;
            end
            drac_pkg::OP_STORE: begin
                decoded.imm      = imm_s;
                decoded.fu       = drac_pkg::STORE;
                decoded.use_rs1  = 1'b1;  // Base address
                decoded.use_rs2  = 1'b1;  // Store data
            end
            drac_pkg::OP_OP_IMM: begin
                decoded.imm      = imm_i;
                decoded.fu       = drac_pkg::ALU;
                decoded.use_rs1  = 1'b1;
                decoded.regwrite = 1'b1;
            end
            drac_pkg::OP_OP: begin
                decoded.fu       = (funct7 == drac_pkg::FUNCT7_MULDIV) ?
                                   drac_pkg::MUL_DIV : drac_pkg::ALU;
                decoded.use_rs1  = 1'b1;
                decoded.use_rs2  = 1'b1;
                decoded.regwrite = 1'b1;
            end
            drac_pkg::OP_MISC_MEM: begin
                decoded.imm      = imm_i;  // Fence, no register traffic
                decoded.fu       = drac_pkg::SYSTEM;
            end
            drac_pkg::OP_SYSTEM: begin
                decoded.imm      = imm_i;  // CSR address or ecall/ebreak code
                decoded.fu       = drac_pkg::SYSTEM;
                decoded.use_rs1  = 1'b1;
                decoded.regwrite = 1'b1;
            end
            default: decoded.illegal = 1'b1;  // Class stays NONE, no writeback
        endcase
        if (decoded.rd == '0) begin
            decoded.regwrite = 1'b0;  // Writes to x0 are dropped
        end
    end

    assign next_bundle.instr            = decoded;
    assign next_bundle.ex_if_page_fault = page_fault_i;

    // Keep a valid bundle the queue could not take
    assign hold          = iq_full_i & decode_o.instr.valid;
    assign fetch_stall_o = hold;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (~rstn_i) begin
            decode_o <= '0;
        end else if (flush_i) begin
            decode_o <= '0;
        end else if (~hold) begin
            decode_o <= next_bundle;
        end
    end

endmodule

// ==== hw/drac_pkg.sv ====
package drac_pkg;

    // Queue sizing, depth must stay a power of two
    localparam int INSTRUCTION_QUEUE_NUM_ENTRIES = 8;
    localparam int IQ_PTR_BITS = $clog2(INSTRUCTION_QUEUE_NUM_ENTRIES);

    // Register file sizing
    localparam int NUM_ARCH_REGS  = 32;
    localparam int NUM_PHYS_REGS  = 64;
    localparam int PHYS_ADDR_BITS = 6;
    localparam int FIRST_FREE_TAG = 32;  // Tags below this hold the identity map

    // RV32I major opcodes
    localparam logic [6:0] OP_LUI      = 7'b0110111;
    localparam logic [6:0] OP_AUIPC    = 7'b0010111;
    localparam logic [6:0] OP_JAL      = 7'b1101111;
    localparam logic [6:0] OP_JALR     = 7'b1100111;
    localparam logic [6:0] OP_BRANCH   = 7'b1100011;
    localparam logic [6:0] OP_LOAD     = 7'b0000011;
    localparam logic [6:0] OP_STORE    = 7'b0100011;
    localparam logic [6:0] OP_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_OP       = 7'b0110011;
    localparam logic [6:0] OP_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OP_SYSTEM   = 7'b1110011;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;  // M extension on OP

    typedef logic [4:0]                  reg_t;       // Architectural index
    typedef logic [PHYS_ADDR_BITS-1:0]   phys_reg_t;  // Physical tag
    typedef logic [IQ_PTR_BITS-1:0]      iq_ptr_t;
    typedef logic [IQ_PTR_BITS:0]        iq_num_t;    // One bit wider than pointers

    typedef enum logic [2:0] {
        ALU,
        MUL_DIV,
        LOAD,
        STORE,
        BRANCH,
        JUMP,
        SYSTEM,
        NONE
    } fu_class_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        reg_t        rs1;
        reg_t        rs2;
        reg_t        rd;
        logic        use_rs1;
        logic        use_rs2;
        logic        regwrite;   // Low for rd == x0
        logic [31:0] imm;        // Already sign extended
        fu_class_t   fu;
        logic        illegal;
    } instr_t;

    // Decode to rename
    typedef struct packed {
        instr_t instr;
        logic   ex_if_page_fault;  // Raised by fetch, carried along
    } id_ir_stage_t;

    // Rename output
    typedef struct packed {
        instr_t    instr;
        phys_reg_t prs1;
        phys_reg_t prs2;
        phys_reg_t prd;
        phys_reg_t old_prd;
    } ir_rr_stage_t;

endpackage

// ==== hw/frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,
    input  logic                   fetch_valid_i,
    input  logic                   page_fault_i,
    input  logic                   rr_stall_i,
    input  logic [31:0]            pc_i,
    input  logic [31:0]            instr_word_i,
    output logic                   fetch_stall_o,
    output logic                   iq_full_o,
    output drac_pkg::ir_rr_stage_t renamed_o
);

    drac_pkg::id_ir_stage_t decode_bundle;  // Decode register into the queue
    drac_pkg::id_ir_stage_t iq_head;        // Queue head seen by rename
    logic                   iq_full;
    logic                   iq_empty;
    logic                   read_head;

    assign iq_full_o = iq_full;

    decode_unit u_decode (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid_i),
        .page_fault_i  (page_fault_i),
        .pc_i          (pc_i),
        .instr_word_i  (instr_word_i),
        .iq_full_i     (iq_full),
        .decode_o      (decode_bundle),
        .fetch_stall_o (fetch_stall_o)
    );

    instruction_queue u_iq (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .read_head_i   (read_head),
        .instruction_i (decode_bundle),
        .instruction_o (iq_head),
        .full_o        (iq_full),
        .empty_o       (iq_empty)
    );

    rename_table u_rename (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .flush_i     (flush_i),
        .iq_head_i   (iq_head),
        .iq_empty_i  (iq_empty),
        .rr_stall_i  (rr_stall_i),
        .read_head_o (read_head),
        .renamed_o   (renamed_o)
    );

endmodule

// ==== hw/instruction_queue.sv ====
`timescale 1ns/1ps

module instruction_queue (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,        // Drops every entry
    input  logic                   read_head_i,    // Pop pulse from rename
    input  drac_pkg::id_ir_stage_t instruction_i,  // instr.valid is the write strobe
    output drac_pkg::id_ir_stage_t instruction_o,  // Head entry, zero when empty
    output logic                   full_o,
    output logic                   empty_o
);

    drac_pkg::iq_ptr_t head;  // Oldest entry
    drac_pkg::iq_ptr_t tail;  // Next free slot
    drac_pkg::iq_num_t num;   // Occupancy
    logic              write_enable;
    logic              read_enable;

    drac_pkg::id_ir_stage_t buffer_q [drac_pkg::INSTRUCTION_QUEUE_NUM_ENTRIES];

    // A full queue ignores the write even if the head pops this cycle
    assign write_enable = instruction_i.instr.valid &
                          (num < drac_pkg::iq_num_t'(drac_pkg::INSTRUCTION_QUEUE_NUM_ENTRIES));
    assign read_enable  = read_head_i & (num != '0);

    // Storage
    always_ff @(posedge clk_i) begin
        if (write_enable) begin
            buffer_q[tail] <= instruction_i;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (~rstn_i) begin
            head <= '0;
            tail <= '0;
            num  <= '0;
        end else if (flush_i) begin
            head <= '0;
            tail <= '0;
            num  <= '0;
        end else begin
            head <= head + drac_pkg::iq_ptr_t'(read_enable);   // Wraps on power of two
            tail <= tail + drac_pkg::iq_ptr_t'(write_enable);
            num  <= num + drac_pkg::iq_num_t'(write_enable)
                        - drac_pkg::iq_num_t'(read_enable);
        end
    end

    assign empty_o       = (num == '0);
    assign instruction_o = empty_o ? '0 : buffer_q[head];
    // Reported full while in reset so nothing is pushed
    assign full_o        = (num == drac_pkg::iq_num_t'(drac_pkg::INSTRUCTION_QUEUE_NUM_ENTRIES))
                           | ~rstn_i;

endmodule

// ==== hw/rename_table.sv ====
`timescale 1ns/1ps

module rename_table (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,     // Back to identity map
    input  drac_pkg::id_ir_stage_t iq_head_i,
    input  logic                   iq_empty_i,
    input  logic                   rr_stall_i,  // Back end cannot take more
    output logic                   read_head_o,
    output drac_pkg::ir_rr_stage_t renamed_o
);

    drac_pkg::phys_reg_t    map_table [drac_pkg::NUM_ARCH_REGS];
    drac_pkg::phys_reg_t    alloc_q;     // Next tag to hand out
    drac_pkg::phys_reg_t    alloc_next;
    drac_pkg::instr_t       head_instr;
    drac_pkg::ir_rr_stage_t renamed_d;
    logic                   pop;
    logic                   do_alloc;

    assign head_instr = iq_head_i.instr;

    // Single place that pops the queue
    assign pop         = ~iq_empty_i & ~rr_stall_i & ~flush_i;
    assign read_head_o = pop;
    assign do_alloc    = pop & head_instr.regwrite;

    // Allocator stays inside the upper half of the tag space
    assign alloc_next = (alloc_q == drac_pkg::phys_reg_t'(drac_pkg::NUM_PHYS_REGS - 1)) ?
                        drac_pkg::phys_reg_t'(drac_pkg::FIRST_FREE_TAG) :
                        alloc_q + drac_pkg::phys_reg_t'(1);

    always_comb begin
        renamed_d         = '0;
        renamed_d.instr   = head_instr;
        renamed_d.prs1    = map_table[head_instr.rs1];  // x0 is never remapped
        renamed_d.prs2    = map_table[head_instr.rs2];
        if (head_instr.regwrite) begin
            renamed_d.prd     = alloc_q;
            renamed_d.old_prd = map_table[head_instr.rd];
        end
    end

    // Map table, identity after reset or flush
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (~rstn_i) begin
            for (int i = 0; i < drac_pkg::NUM_ARCH_REGS; i++) begin
                map_table[i] <= drac_pkg::phys_reg_t'(i);
            end
        end else if (flush_i) begin
            for (int i = 0; i < drac_pkg::NUM_ARCH_REGS; i++) begin
                map_table[i] <= drac_pkg::phys_reg_t'(i);
            end
        end else if (do_alloc) begin
            map_table[head_instr.rd] <= alloc_q;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (~rstn_i) begin
            alloc_q <= drac_pkg::phys_reg_t'(drac_pkg::FIRST_FREE_TAG);
        end else if (flush_i) begin
            alloc_q <= drac_pkg::phys_reg_t'(drac_pkg::FIRST_FREE_TAG);
        end else if (do_alloc) begin
            alloc_q <= alloc_next;
        end
    end

    // Output register, one cycle after the pop
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (~rstn_i) begin
            renamed_o <= '0;
        end else if (flush_i) begin
            renamed_o <= '0;
        end else if (pop) begin
            renamed_o <= renamed_d;
        end else begin
            renamed_o.instr.valid <= 1'b0;  // Payload kept, no new instruction
        end
    end

endmodule

// ==== tests/tb_frontend_top.sv ====
`timescale 1ns/1ps

module tb_frontend_top;

    typedef enum logic [2:0] {FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J} imm_fmt_t;

    typedef struct packed {
        drac_pkg::fu_class_t fu;
        logic [2:0]          uses;  // use_rs1, use_rs2, regwrite
        imm_fmt_t            fmt;
    } op_info_t;

    logic                   clk_i;
    logic                   rstn_i;
    logic                   flush_i;
    logic                   fetch_valid_i;
    logic                   page_fault_i;
    logic                   rr_stall_i;
    logic [31:0]            pc_i;
    logic [31:0]            instr_word_i;
    logic                   fetch_stall_o;
    logic                   iq_full_o;
    drac_pkg::ir_rr_stage_t renamed_o;

    logic [31:0]            lfsr;
    logic [31:0]            next_pc;
    int                     mismatches;
    int                     other_errors;
    string                  test_name;
    drac_pkg::instr_t       expected_q [$];  // Accepted fetches in program order
    drac_pkg::instr_t       exp_instr;
    drac_pkg::ir_rr_stage_t exp_rr;
    drac_pkg::phys_reg_t    ref_map [drac_pkg::NUM_ARCH_REGS];
    drac_pkg::phys_reg_t    ref_alloc;

    // Legal opcodes first, entry 11 is OP forced to the M extension, then illegal ones
    logic [6:0] op_table [16] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h13,
                                  7'h33, 7'h0f, 7'h73, 7'h33, 7'h7f, 7'h00, 7'h5b, 7'h2b};

    frontend_top u_dut (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid_i),
        .page_fault_i  (page_fault_i),
        .rr_stall_i    (rr_stall_i),
        .pc_i          (pc_i),
        .instr_word_i  (instr_word_i),
        .fetch_stall_o (fetch_stall_o),
        .iq_full_o     (iq_full_o),
        .renamed_o     (renamed_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};  // One step per bit
        end
        return r;
    endfunction

    // Expected decode straight from the RV32I encoding
    function automatic drac_pkg::instr_t ref_decode(logic [31:0] w, logic [31:0] pc);
        drac_pkg::instr_t d;
        op_info_t         info;
        logic             legal;
        legal = 1'b1;
        case (w[6:0])
            7'h37, 7'h17: info = '{drac_pkg::ALU, 3'b001, FMT_U};  // LUI, AUIPC
            7'h6f:        info = '{drac_pkg::JUMP, 3'b001, FMT_J};
            7'h67:        info = '{drac_pkg::JUMP, 3'b101, FMT_I};
            7'h63:        info = '{drac_pkg::BRANCH, 3'b110, FMT_B};
            7'h03:        info = '{drac_pkg::LOAD, 3'b101, FMT_I};
            7'h23:        info = '{drac_pkg::STORE, 3'b110, FMT_S};
            7'h13:        info = '{drac_pkg::ALU, 3'b101, FMT_I};
            7'h33:        info = '{(w[31:25] == 7'b0000001) ? drac_pkg::MUL_DIV : drac_pkg::ALU,
                                   3'b111, FMT_R};
            7'h0f:        info = '{drac_pkg::SYSTEM, 3'b000, FMT_I};  // FENCE
            7'h73:        info = '{drac_pkg::SYSTEM, 3'b101, FMT_I};
            default: begin
                info  = '{drac_pkg::NONE, 3'b000, FMT_R};
                legal = 1'b0;
            end
        endcase
        d          = '0;
        d.valid    = 1'b1;
        d.pc       = pc;
        d.rs1      = w[19:15];
        d.rs2      = w[24:20];
        d.rd       = w[11:7];
        d.fu       = info.fu;
        d.use_rs1  = info.uses[2];
        d.use_rs2  = info.uses[1];
        d.regwrite = info.uses[0] & (w[11:7] != 5'd0);  // x0 is never written
        d.illegal  = ~legal;
        case (info.fmt)
            FMT_I:   d.imm = {{20{w[31]}}, w[31:20]};
            FMT_S:   d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            FMT_B:   d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            FMT_U:   d.imm = {w[31:12], 12'h000};
            FMT_J:   d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: d.imm = '0;  // R type and illegal
        endcase
        return d;
    endfunction

    function automatic drac_pkg::ir_rr_stage_t ref_rename(drac_pkg::instr_t ins);
        drac_pkg::ir_rr_stage_t r;
        r       = '0;
        r.instr = ins;
        r.prs1  = ref_map[ins.rs1];
        r.prs2  = ref_map[ins.rs2];
        if (ins.regwrite) begin
            r.prd     = ref_alloc;
            r.old_prd = ref_map[ins.rd];
        end
        return r;
    endfunction

    // Round robin over the free pool, offset taken modulo the pool size
    function automatic drac_pkg::phys_reg_t next_tag(drac_pkg::phys_reg_t tag);
        int pool;
        int offset;
        pool   = drac_pkg::NUM_PHYS_REGS - drac_pkg::FIRST_FREE_TAG;
        offset = (int'(tag) - drac_pkg::FIRST_FREE_TAG + 1) % pool;
        return drac_pkg::phys_reg_t'(drac_pkg::FIRST_FREE_TAG + offset);
    endfunction

    task automatic reset_model();
        for (int i = 0; i < drac_pkg::NUM_ARCH_REGS; i++) begin
            ref_map[i] = drac_pkg::phys_reg_t'(i);  // Identity map
        end
        ref_alloc = drac_pkg::phys_reg_t'(drac_pkg::FIRST_FREE_TAG);
    endtask

    task automatic check_renamed(string name, drac_pkg::ir_rr_stage_t exp,
                                 drac_pkg::ir_rr_stage_t act);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s: expected %b actual %b", name, exp, act);
        end
    endtask

    // Offer one random word, return once decode has taken it
    task automatic fetch_random();
        logic [3:0]  idx;
        logic [31:0] word;
        int          cnt;
        idx        = 4'(take_bits(4));
        word[31:7] = 25'(take_bits(25));
        word[6:0]  = op_table[idx];
        if (idx == 4'd11) begin
            word[31:25] = 7'b0000001;  // MUL/DIV
        end
        @(posedge clk_i);
        fetch_valid_i <= 1'b1;
        pc_i          <= next_pc;
        instr_word_i  <= word;
        cnt = 0;
        @(negedge clk_i);
        while (fetch_stall_o) begin  // Inputs stay put while stalled
            if (cnt == 500) begin
                other_errors++;
                $display("Error: %s fetch stayed stalled past the timeout", test_name);
                break;
            end
            @(negedge clk_i);
            cnt++;
        end
        expected_q.push_back(ref_decode(word, next_pc));  // Counted once
        next_pc = next_pc + 32'd4;
    endtask

    task automatic stop_fetch();
        @(posedge clk_i);
        fetch_valid_i <= 1'b0;
    endtask

    task automatic wait_stall_high();
        int cnt;
        cnt = 0;
        while (!fetch_stall_o) begin
            if (cnt == 500) begin
                other_errors++;
                $display("Error: %s fetch_stall_o never rose with the back end stalled",
                         test_name);
                break;
            end
            @(negedge clk_i);
            cnt++;
        end
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (expected_q.size() != 0) begin
            if (cnt == 500) begin
                other_errors++;
                $display("Error: %s %0d instructions never left rename", test_name,
                         expected_q.size());
                break;
            end
            @(negedge clk_i);
            cnt++;
        end
        repeat (4) @(negedge clk_i);  // Room for a stray duplicate to show up
    endtask

    // Comparison process, one renamed instruction per cycle at most
    always @(negedge clk_i) begin
        if (rstn_i && renamed_o.instr.valid) begin
            if (expected_q.size() == 0) begin
                other_errors++;
                $display("Error: %s renamed_o showed an instruction nobody was waiting for",
                         test_name);
            end else begin
                exp_instr = expected_q.pop_front();
                exp_rr    = ref_rename(exp_instr);
                check_renamed(test_name, exp_rr, renamed_o);
                if (exp_instr.regwrite) begin
                    ref_map[exp_instr.rd] = ref_alloc;
                    ref_alloc             = next_tag(ref_alloc);
                end
            end
        end
    end

    initial begin
        rstn_i        = 1'b0;
        flush_i       = 1'b0;
        fetch_valid_i = 1'b0;
        page_fault_i  = 1'b0;
        rr_stall_i    = 1'b0;
        pc_i          = '0;
        instr_word_i  = '0;
        lfsr          = 32'hd226;
        next_pc       = 32'h8000_0000;
        mismatches    = 0;
        other_errors  = 0;
        test_name     = "reset";
        reset_model();
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        check_flag("reset_iq_full_in_reset", 1'b1, iq_full_o);
        @(posedge clk_i);
        rstn_i <= 1'b1;  // Fifth edge releases reset
        @(negedge clk_i);
        check_flag("reset_renamed_valid", 1'b0, renamed_o.instr.valid);
        check_flag("reset_fetch_stall", 1'b0, fetch_stall_o);
        check_flag("reset_iq_full", 1'b0, iq_full_o);

        // Long random stream, enough writers to wrap the allocator
        test_name = "decode_rename";
        repeat (80) fetch_random();
        stop_fetch();
        wait_drain();

        // Eight entries fill the queue and the ninth parks in decode
        test_name = "backpressure";
        @(posedge clk_i);
        rr_stall_i <= 1'b1;
        repeat (9) fetch_random();
        stop_fetch();
        wait_stall_high();
        check_flag("backpressure_iq_full", 1'b1, iq_full_o);
        repeat (4) @(posedge clk_i);
        rr_stall_i <= 1'b0;
        wait_drain();

        // Queued work is dropped and the map returns to identity
        test_name = "flush";
        @(posedge clk_i);
        rr_stall_i <= 1'b1;
        repeat (5) fetch_random();
        stop_fetch();
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i    <= 1'b0;
        rr_stall_i <= 1'b0;
        expected_q.delete();
        reset_model();
        repeat (20) fetch_random();
        stop_fetch();
        wait_drain();

        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
